// ==== project.f ====
hdl/rv_pkg.sv
hdl/core_control.sv
hdl/inst_decode.sv
hdl/register_file.sv
hdl/alu.sv
hdl/bus_arbiter.sv
hdl/bus_router.sv
hdl/machine_timer.sv
hdl/rv_core_top.sv
verif/rv_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail.
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --top-module rv_core_tb -f project.f \
  --Mdir obj_dir -o rv_core_sim > build.log 2>&1 \
  && ./obj_dir/rv_core_sim > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
exit 0

// ==== verif/rv_core_tb.sv ====
`timescale 1ns/1ps

module rv_core_tb;

  localparam int num_entries = 54;
  localparam int mem_words = 1024;
  localparam int watchdog_cycles = 200 * num_entries;
  localparam logic [31:0] timer_base = 32'hA000_0000;

  localparam logic [1:0] ev_none = 2'd0;
  localparam logic [1:0] ev_store = 2'd1;
  localparam logic [1:0] ev_halt = 2'd2;
  localparam logic [1:0] ev_timer = 2'd3; // Timer value store with a range check.

  logic        clock = 1'b0;
  logic        reset = 1'b1;
  logic        ext_req_valid;
  logic        ext_req_ready = 1'b0;
  logic        ext_req_write;
  logic [31:0] ext_req_addr;
  logic [31:0] ext_req_wdata;
  logic [3:0]  ext_req_wstrb;
  logic        ext_resp_valid = 1'b0;
  logic [31:0] ext_resp_rdata = 32'h0;
  logic        commit_valid;
  logic [31:0] commit_pc;
  logic        halted;

  logic [31:0] table_inst [num_entries];
  logic        table_on_path [num_entries];
  logic [1:0]  table_kind [num_entries];
  logic [31:0] table_addr [num_entries];
  logic [31:0] table_data [num_entries];
  int          entry_count = 0;

  logic [31:0] mem [mem_words];
  logic [1:0]  ready_delay_table [256];
  logic [2:0]  latency_table [256];
  logic [7:0]  request_count;
  logic [1:0]  ready_delay;
  logic [2:0]  resp_delay;
  logic        pending;
  logic [9:0]  read_index;

  int          errors = 0;
  int          checks = 0;
  int          missing = 0;
  int          store_index = 0;
  int          commit_index = 0;
  logic        halt_seen = 1'b0;
  logic        timer_seen = 1'b0;
  logic [31:0] timer_first = 32'h0;
  int unsigned seed_value;

  rv_core_top #(
    .reset_pc   (32'h0000_0000),
    .timer_base (timer_base)
  ) dut (
    .clock          (clock),
    .reset          (reset),
    .ext_req_valid  (ext_req_valid),
    .ext_req_ready  (ext_req_ready),
    .ext_req_write  (ext_req_write),
    .ext_req_addr   (ext_req_addr),
    .ext_req_wdata  (ext_req_wdata),
    .ext_req_wstrb  (ext_req_wstrb),
    .ext_resp_valid (ext_resp_valid),
    .ext_resp_rdata (ext_resp_rdata),
    .commit_valid   (commit_valid),
    .commit_pc      (commit_pc),
    .halted         (halted)
  );

  always #5 clock = ~clock;

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, name, actual, expected);
    end
  endtask

  task automatic add_entry(input logic [31:0] inst, input logic on_path, input logic [1:0] kind,
                           input logic [31:0] addr, input logic [31:0] data);
    table_inst[entry_count]    = inst;
    table_on_path[entry_count] = on_path;
    table_kind[entry_count]    = kind;
    table_addr[entry_count]    = addr;
    table_data[entry_count]    = data;
    entry_count++;
  endtask

  // Program at address 0 with x10 as the store base 0x200.
  task automatic load_program();
    add_entry(32'h20000513, 1, ev_none, 0, 0);                     // addi x10, x0, 0x200
    add_entry(32'h06400093, 1, ev_none, 0, 0);                     // addi x1, x0, 100
    add_entry(32'hFF900113, 1, ev_none, 0, 0);                     // addi x2, x0, -7
    add_entry(32'h002081B3, 1, ev_none, 0, 0);                     // add x3, x1, x2
    add_entry(32'h00352023, 1, ev_store, 32'h200, 32'h0000005D);
    add_entry(32'h40208233, 1, ev_none, 0, 0);                     // sub x4, x1, x2
    add_entry(32'h00452223, 1, ev_store, 32'h204, 32'h0000006B);
    add_entry(32'h0020C1B3, 1, ev_none, 0, 0);                     // xor
    add_entry(32'h00352423, 1, ev_store, 32'h208, 32'hFFFFFF9D);
    add_entry(32'h0020E1B3, 1, ev_none, 0, 0);                     // or
    add_entry(32'h00352623, 1, ev_store, 32'h20C, 32'hFFFFFFFD);
    add_entry(32'h0020F1B3, 1, ev_none, 0, 0);                     // and
    add_entry(32'h00352823, 1, ev_store, 32'h210, 32'h00000060);
    add_entry(32'h00409193, 1, ev_none, 0, 0);                     // slli x3, x1, 4
    add_entry(32'h00352A23, 1, ev_store, 32'h214, 32'h00000640);
    add_entry(32'h40115193, 1, ev_none, 0, 0);                     // srai x3, x2, 1
    add_entry(32'h00352C23, 1, ev_store, 32'h218, 32'hFFFFFFFC);
    add_entry(32'h01C15193, 1, ev_none, 0, 0);                     // srli x3, x2, 28
    add_entry(32'h00352E23, 1, ev_store, 32'h21C, 32'h0000000F);
    add_entry(32'h001121B3, 1, ev_none, 0, 0);                     // slt x3, x2, x1
    add_entry(32'h00113233, 1, ev_none, 0, 0);                     // sltu x4, x2, x1
    add_entry(32'h02352023, 1, ev_store, 32'h220, 32'h00000001);
    add_entry(32'h02452223, 1, ev_store, 32'h224, 32'h00000000);
    add_entry(32'h12345337, 1, ev_none, 0, 0);                     // lui x6, 0x12345
    add_entry(32'h00001397, 1, ev_none, 0, 0);                     // auipc x7, 1
    add_entry(32'h02652423, 1, ev_store, 32'h228, 32'h12345000);
    add_entry(32'h02752623, 1, ev_store, 32'h22C, 32'h00001060);
    add_entry(32'h00208463, 1, ev_none, 0, 0);                     // beq not taken
    add_entry(32'h00209463, 1, ev_none, 0, 0);                     // bne taken
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h00114463, 1, ev_none, 0, 0);                     // blt taken
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h00116463, 1, ev_none, 0, 0);                     // bltu not taken
    add_entry(32'h00117463, 1, ev_none, 0, 0);                     // bgeu taken
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h0020D463, 1, ev_none, 0, 0);                     // bge taken
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h0080046F, 1, ev_none, 0, 0);                     // jal x8, +8
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h02852823, 1, ev_store, 32'h230, 32'h00000098);
    add_entry(32'h011404E7, 1, ev_none, 0, 0);                     // jalr x9, 17(x8)
    add_entry(32'h02052823, 0, ev_none, 0, 0);
    add_entry(32'h02952A23, 1, ev_store, 32'h234, 32'h000000A4);
    add_entry(32'h02152C23, 1, ev_store, 32'h238, 32'h00000064);
    add_entry(32'h03852583, 1, ev_none, 0, 0);                     // lw x11, 56(x10)
    add_entry(32'h02B52E23, 1, ev_store, 32'h23C, 32'h00000064);
    add_entry(32'h00500013, 1, ev_none, 0, 0);                     // addi x0, x0, 5
    add_entry(32'h04052023, 1, ev_store, 32'h240, 32'h00000000);
    add_entry(32'hA00002B7, 1, ev_none, 0, 0);                     // lui x5, timer base
    add_entry(32'h0002A603, 1, ev_none, 0, 0);
    add_entry(32'h0002A683, 1, ev_none, 0, 0);
    add_entry(32'h04C52223, 1, ev_timer, 32'h244, 0);
    add_entry(32'h04D52423, 1, ev_timer, 32'h248, 0);
    add_entry(32'h00100073, 1, ev_halt, 0, 0);                     // ebreak
  endtask

  function automatic int store_entry_from(input int start);
    for (int i = start; i < entry_count; i++) begin
      if (table_on_path[i] && (table_kind[i] == ev_store || table_kind[i] == ev_timer)) return i;
    end
    return entry_count;
  endfunction

  function automatic int path_entry_from(input int start);
    for (int i = start; i < entry_count; i++) begin
      if (table_on_path[i]) return i;
    end
    return entry_count;
  endfunction

  task automatic bound_timer_read(input logic [31:0] value);
    if (!timer_seen) begin
      timer_first = value;
      timer_seen  = 1'b1;
    end else begin
      check("timer read in range", 32'((value > timer_first) &&
            (value < timer_first + 32'(watchdog_cycles))), 32'd1);
    end
  endtask

  task automatic verify_store();
    store_index = store_entry_from(store_index);
    if (store_index >= entry_count) begin
      errors++;
      $display("Error at time %0t: unexpected store of 0x%08h to 0x%08h after the last one",
               $time, ext_req_wdata, ext_req_addr);
    end else begin
      check("ext_req_addr", ext_req_addr, table_addr[store_index]);
      check("ext_req_wstrb", 32'(ext_req_wstrb), 32'hF);
      if (table_kind[store_index] == ev_timer) begin
        bound_timer_read(ext_req_wdata);
      end else begin
        check("ext_req_wdata", ext_req_wdata, table_data[store_index]);
      end
      store_index++;
    end
  endtask

  task automatic follow_commit();
    commit_index = path_entry_from(commit_index);
    if (halt_seen) begin
      errors++;
      $display("Error at time %0t: instruction at 0x%08h retired after halt", $time, commit_pc);
    end else if (commit_index >= entry_count) begin
      errors++;
      $display("Error at time %0t: instruction at 0x%08h retired off the path", $time, commit_pc);
    end else begin
      check("commit_pc", commit_pc, 32'(commit_index * 4));
      if (table_kind[commit_index] == ev_halt) check("halted", 32'(halted), 32'd1);
      commit_index++;
    end
  endtask

  // Memory model on the external port.
  always @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < mem_words; i++) begin
        mem[i] <= ~32'(i * 4); // Inverted byte address.
      end
      for (int i = 0; i < num_entries; i++) begin
        mem[i] <= table_inst[i];
      end
      ext_req_ready  <= 1'b0;
      ext_resp_valid <= 1'b0;
      pending        <= 1'b0;
      request_count  <= 8'd0;
      ready_delay    <= ready_delay_table[0];
      resp_delay     <= 3'd1;
      read_index     <= 10'd0;
    end else begin
      ext_resp_valid <= 1'b0;
      if (ext_req_valid && ext_req_ready) begin
        ext_req_ready <= 1'b0;
        pending       <= 1'b1;
        resp_delay    <= latency_table[request_count];
        ready_delay   <= ready_delay_table[request_count + 8'd1];
        request_count <= request_count + 8'd1;
        read_index    <= ext_req_addr[11:2];
        if (ext_req_write) mem[ext_req_addr[11:2]] <= ext_req_wdata;
      end else if (ext_req_valid && !pending) begin
        if (ready_delay == 2'd0) begin
          ext_req_ready <= 1'b1;
        end else begin
          ready_delay <= ready_delay - 2'd1;
        end
      end
      if (pending) begin
        if (resp_delay == 3'd1) begin
          ext_resp_valid <= 1'b1;
          ext_resp_rdata <= mem[read_index];
          pending        <= 1'b0;
        end else begin
          resp_delay <= resp_delay - 3'd1;
        end
      end
    end
  end

  // Bus, commit and halt monitor.
  always @(posedge clock) begin
    if (!reset) begin
      if (ext_req_valid && halt_seen) begin
        errors++;
        $display("Error at time %0t: external request to 0x%08h after halt", $time, ext_req_addr);
      end
      if (ext_req_valid && ext_req_ready) begin
        check("ext_req_addr in timer window", 32'(ext_req_addr[31:4] == timer_base[31:4]), 32'd0);
        if (ext_req_write) verify_store();
      end
      if (commit_valid) follow_commit();
      if (halt_seen) check("halted", 32'(halted), 32'd1);
      halt_seen = halt_seen | halted;
    end
  end

  initial begin
    seed_value = $urandom(32717);
    for (int i = 0; i < 256; i++) begin
      ready_delay_table[i] = 2'($urandom_range(0, 3));
      latency_table[i]     = 3'($urandom_range(1, 4));
    end
    load_program();
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    wait (halted === 1'b1);
    repeat (50) @(posedge clock);
    @(negedge clock);
    if (store_entry_from(store_index) < entry_count) begin
      missing++;
      $display("Stores from table entry %0d on never appeared", store_entry_from(store_index));
    end
    if (path_entry_from(commit_index) < entry_count) begin
      missing++;
      $display("Instructions from table entry %0d on never retired", path_entry_from(commit_index));
    end
    $display("Checks: %0d, errors: %0d, missing events: %0d", checks, errors, missing);
    if (errors == 0 && missing == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clock);
    $display("The run timed out after %0d cycles without reaching the end", watchdog_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps

module rv_core_top #(
  parameter logic [rv_pkg::word_width-1:0] reset_pc   = 32'h0000_0000,
  parameter logic [rv_pkg::word_width-1:0] timer_base = 32'hA000_0000
) (
  input  logic                          clock,
  input  logic                          reset,
  output logic                          ext_req_valid,
  input  logic                          ext_req_ready,
  output logic                          ext_req_write,
  output logic [rv_pkg::word_width-1:0] ext_req_addr,
  output logic [rv_pkg::word_width-1:0] ext_req_wdata,
  output logic [3:0]                    ext_req_wstrb,
  input  logic                          ext_resp_valid,
  input  logic [rv_pkg::word_width-1:0] ext_resp_rdata,
  output logic                          commit_valid,
  output logic [rv_pkg::word_width-1:0] commit_pc,
  output logic                          halted
);
  import rv_pkg::*;

  logic [word_width-1:0] inst;
  logic [word_width-1:0] pc;
  logic [word_width-1:0] imm;
  logic [word_width-1:0] rs1_data;
  logic [word_width-1:0] rs2_data;
  logic [word_width-1:0] rd_data;
  logic [word_width-1:0] alu_result;
  logic [word_width-1:0] operand_a;
  logic [word_width-1:0] operand_b;
  logic [4:0]            rs1;
  logic [4:0]            rs2;
  logic [4:0]            rd;
  logic                  rd_write;
  logic                  branch_taken;
  logic                  alu_src_imm;
  logic                  alu_src_pc;
  alu_op_t               alu_op;
  inst_class_t           inst_class;

  logic                  fetch_req_valid;
  logic                  fetch_req_ready;
  logic [word_width-1:0] fetch_req_addr;
  logic                  fetch_resp_valid;
  logic [word_width-1:0] fetch_resp_rdata;
  logic                  lsu_req_valid;
  logic                  lsu_req_ready;
  logic                  lsu_req_write;
  logic [word_width-1:0] lsu_req_addr;
  logic [word_width-1:0] lsu_req_wdata;
  logic [3:0]            lsu_req_wstrb;
  logic                  lsu_resp_valid;
  logic [word_width-1:0] lsu_resp_rdata;
  logic                  bus_req_valid;
  logic                  bus_req_ready;
  logic                  bus_req_write;
  logic [word_width-1:0] bus_req_addr;
  logic [word_width-1:0] bus_req_wdata;
  logic [3:0]            bus_req_wstrb;
  logic                  bus_resp_valid;
  logic [word_width-1:0] bus_resp_rdata;
  logic                  timer_req_valid;
  logic                  timer_req_ready;
  logic [word_width-1:0] timer_req_addr;
  logic                  timer_resp_valid;
  logic [word_width-1:0] timer_resp_rdata;

  assign operand_a = alu_src_pc ? pc : rs1_data;
  assign operand_b = alu_src_imm ? imm : rs2_data;

  core_control #(.reset_pc(reset_pc)) u_control (.*);

  inst_decode u_decode (.*);

  register_file u_regs (.*);

  alu u_alu (
    .operand_a    (operand_a),
    .operand_b    (operand_b),
    .alu_op       (alu_op),
    .branch_funct (inst[14:12]),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

  bus_arbiter u_arbiter (.*);

  bus_router #(.timer_base(timer_base)) u_router (.*);

  machine_timer u_timer (.*);

endmodule

// ==== hdl/machine_timer.sv ====
`timescale 1ns/1ps

module machine_timer (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          timer_req_valid,
  output logic                          timer_req_ready,
  input  logic [rv_pkg::word_width-1:0] timer_req_addr,
  output logic                          timer_resp_valid,
  output logic [rv_pkg::word_width-1:0] timer_resp_rdata
);

  logic [63:0] count;

  assign timer_req_ready = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      count            <= '0;
      timer_resp_valid <= 1'b0;
    end else begin
      count            <= count + 64'd1;
      timer_resp_valid <= timer_req_valid; // Writes get an empty response.
    end
  end

  always_ff @(posedge clock) begin
    if (timer_req_valid) begin
      timer_resp_rdata <= timer_req_addr[2] ? count[63:32] : count[31:0];
    end
  end

endmodule

// ==== hdl/bus_router.sv ====
`timescale 1ns/1ps

module bus_router #(
  parameter logic [rv_pkg::word_width-1:0] timer_base = 32'hA000_0000
) (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          bus_req_valid,
  output logic                          bus_req_ready,
  input  logic                          bus_req_write,
  input  logic [rv_pkg::word_width-1:0] bus_req_addr,
  input  logic [rv_pkg::word_width-1:0] bus_req_wdata,
  input  logic [3:0]                    bus_req_wstrb,
  output logic                          bus_resp_valid,
  output logic [rv_pkg::word_width-1:0] bus_resp_rdata,
  output logic                          timer_req_valid,
  input  logic                          timer_req_ready,
  output logic [rv_pkg::word_width-1:0] timer_req_addr,
  input  logic                          timer_resp_valid,
  input  logic [rv_pkg::word_width-1:0] timer_resp_rdata,
  output logic                          ext_req_valid,
  input  logic                          ext_req_ready,
  output logic                          ext_req_write,
  output logic [rv_pkg::word_width-1:0] ext_req_addr,
  output logic [rv_pkg::word_width-1:0] ext_req_wdata,
  output logic [3:0]                    ext_req_wstrb,
  input  logic                          ext_resp_valid,
  input  logic [rv_pkg::word_width-1:0] ext_resp_rdata
);

  logic timer_hit;
  logic target_timer; // Latched at acceptance.

  assign timer_hit = (bus_req_addr[31:4] == timer_base[31:4]); // 16-byte window.

  assign timer_req_valid = bus_req_valid & timer_hit;
  assign timer_req_addr  = bus_req_addr;
  assign ext_req_valid   = bus_req_valid & ~timer_hit;
  assign ext_req_write   = bus_req_write;
  assign ext_req_addr    = bus_req_addr;
  assign ext_req_wdata   = bus_req_wdata;
  assign ext_req_wstrb   = bus_req_wstrb;
  assign bus_req_ready   = timer_hit ? timer_req_ready : ext_req_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      target_timer <= 1'b0;
    end else if (bus_req_valid && bus_req_ready) begin
      target_timer <= timer_hit;
    end
  end

  assign bus_resp_valid = target_timer ? timer_resp_valid : ext_resp_valid;
  assign bus_resp_rdata = target_timer ? timer_resp_rdata : ext_resp_rdata;

endmodule

// ==== hdl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          fetch_req_valid,
  output logic                          fetch_req_ready,
  input  logic [rv_pkg::word_width-1:0] fetch_req_addr,
  output logic                          fetch_resp_valid,
  output logic [rv_pkg::word_width-1:0] fetch_resp_rdata,
  input  logic                          lsu_req_valid,
  output logic                          lsu_req_ready,
  input  logic                          lsu_req_write,
  input  logic [rv_pkg::word_width-1:0] lsu_req_addr,
  input  logic [rv_pkg::word_width-1:0] lsu_req_wdata,
  input  logic [3:0]                    lsu_req_wstrb,
  output logic                          lsu_resp_valid,
  output logic [rv_pkg::word_width-1:0] lsu_resp_rdata,
  output logic                          bus_req_valid,
  input  logic                          bus_req_ready,
  output logic                          bus_req_write,
  output logic [rv_pkg::word_width-1:0] bus_req_addr,
  output logic [rv_pkg::word_width-1:0] bus_req_wdata,
  output logic [3:0]                    bus_req_wstrb,
  input  logic                          bus_resp_valid,
  input  logic [rv_pkg::word_width-1:0] bus_resp_rdata
);

  logic owner_fetch; // Owner of the outstanding request.

  // Fetch wins when both ask.
  assign bus_req_valid = fetch_req_valid | lsu_req_valid;
  assign bus_req_write = fetch_req_valid ? 1'b0 : lsu_req_write;
  assign bus_req_addr  = fetch_req_valid ? fetch_req_addr : lsu_req_addr;
  assign bus_req_wdata = lsu_req_wdata;
  assign bus_req_wstrb = fetch_req_valid ? 4'h0 : lsu_req_wstrb;

  assign fetch_req_ready = bus_req_ready;
  assign lsu_req_ready   = bus_req_ready & ~fetch_req_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      owner_fetch <= 1'b0;
    end else if (bus_req_valid && bus_req_ready) begin
      owner_fetch <= fetch_req_valid;
    end
  end

  assign fetch_resp_valid = bus_resp_valid & owner_fetch;
  assign lsu_resp_valid   = bus_resp_valid & ~owner_fetch;
  assign fetch_resp_rdata = bus_resp_rdata;
  assign lsu_resp_rdata   = bus_resp_rdata;

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
  input  logic [rv_pkg::word_width-1:0] operand_a,
  input  logic [rv_pkg::word_width-1:0] operand_b,
  input  rv_pkg::alu_op_t               alu_op,
  input  logic [2:0]                    branch_funct,
  input  logic [rv_pkg::word_width-1:0] rs1_data,
  input  logic [rv_pkg::word_width-1:0] rs2_data,
  output logic [rv_pkg::word_width-1:0] result,
  output logic                          branch_taken
);
  import rv_pkg::*;

  logic [4:0] shamt;

  assign shamt = operand_b[4:0];

  always_comb begin
    case (alu_op)
      alu_add:    result = operand_a + operand_b;
      alu_sub:    result = operand_a - operand_b;
      alu_sll:    result = operand_a << shamt;
      alu_slt:    result = {{(word_width-1){1'b0}}, $signed(operand_a) < $signed(operand_b)};
      alu_sltu:   result = {{(word_width-1){1'b0}}, operand_a < operand_b};
      alu_xor:    result = operand_a ^ operand_b;
      alu_srl:    result = operand_a >> shamt;
      alu_sra:    result = $signed(operand_a) >>> shamt;
      alu_or:     result = operand_a | operand_b;
      alu_and:    result = operand_a & operand_b;
      alu_pass_b: result = operand_b;
      default:    result = '0;
    endcase
  end

  // Branch compare on register values.
  always_comb begin
    case (branch_funct)
      3'b000:  branch_taken = (rs1_data == rs2_data);
      3'b001:  branch_taken = (rs1_data != rs2_data);
      3'b100:  branch_taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  branch_taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  branch_taken = (rs1_data < rs2_data);
      3'b111:  branch_taken = (rs1_data >= rs2_data);
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [4:0]                    rs1,
  input  logic [4:0]                    rs2,
  input  logic [4:0]                    rd,
  input  logic                          rd_write,
  input  logic [rv_pkg::word_width-1:0] rd_data,
  output logic [rv_pkg::word_width-1:0] rs1_data,
  output logic [rv_pkg::word_width-1:0] rs2_data
);
  import rv_pkg::*;

  logic [word_width-1:0] regs [1:31]; // x0 has no storage.

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_write && rd != 5'd0) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// ==== hdl/inst_decode.sv ====
`timescale 1ns/1ps

module inst_decode (
  input  logic [rv_pkg::word_width-1:0] inst,
  output logic [4:0]                    rs1,
  output logic [4:0]                    rs2,
  output logic [4:0]                    rd,
  output logic [rv_pkg::word_width-1:0] imm,
  output rv_pkg::alu_op_t               alu_op,
  output rv_pkg::inst_class_t           inst_class,
  output logic                          alu_src_imm,
  output logic                          alu_src_pc
);
  import rv_pkg::*;

  opcode_t               opcode;
  logic [2:0]            funct3;
  logic [word_width-1:0] imm_i;
  logic [word_width-1:0] imm_s;
  logic [word_width-1:0] imm_b;
  logic [word_width-1:0] imm_u;
  logic [word_width-1:0] imm_j;

  assign opcode = opcode_t'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign rd     = inst[11:7];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    case (funct3)
      3'b000:  alu_op = (opcode == op_op && inst[30]) ? alu_sub : alu_add;
      3'b001:  alu_op = alu_sll;
      3'b010:  alu_op = alu_slt;
      3'b011:  alu_op = alu_sltu;
      3'b100:  alu_op = alu_xor;
      3'b101:  alu_op = inst[30] ? alu_sra : alu_srl;
      3'b110:  alu_op = alu_or;
      default: alu_op = alu_and;
    endcase
    imm         = imm_i;
    alu_src_imm = 1'b1;
    alu_src_pc  = 1'b0;
    inst_class  = class_alu;
    case (opcode)
      op_lui: begin
        imm    = imm_u;
        alu_op = alu_pass_b;
      end
      op_auipc: begin
        imm        = imm_u;
        alu_src_pc = 1'b1;
        alu_op     = alu_add;
      end
      op_jal: begin
        imm        = imm_j;
        alu_src_pc = 1'b1;
        alu_op     = alu_add;
        inst_class = class_jump;
      end
      op_jalr: begin
        alu_op     = alu_add;
        inst_class = (funct3 == 3'b000) ? class_jump_register : class_illegal;
      end
      op_branch: begin
        imm        = imm_b;
        alu_src_pc = 1'b1; // ALU forms the target.
        alu_op     = alu_add;
        inst_class = (funct3[2:1] == 2'b01) ? class_illegal : class_branch;
      end
      op_load: begin
        alu_op     = alu_add;
        inst_class = (funct3 == 3'b010) ? class_load : class_illegal;
      end
      op_store: begin
        imm        = imm_s;
        alu_op     = alu_add;
        inst_class = (funct3 == 3'b010) ? class_store : class_illegal;
      end
      op_imm:    inst_class = class_alu;
      op_op:     alu_src_imm = 1'b0;
      op_system: inst_class = (inst == 32'h0010_0073) ? class_halt : class_illegal; // ebreak
      default:   inst_class = class_illegal;
    endcase
  end

endmodule

// ==== hdl/core_control.sv ====
`timescale 1ns/1ps

module core_control #(
  parameter logic [rv_pkg::word_width-1:0] reset_pc = 32'h0000_0000
) (
  input  logic                          clock,
  input  logic                          reset,
  input  rv_pkg::inst_class_t           inst_class,
  input  logic [rv_pkg::word_width-1:0] alu_result,
  input  logic                          branch_taken,
  input  logic [rv_pkg::word_width-1:0] rs1_data,
  input  logic [rv_pkg::word_width-1:0] rs2_data,
  input  logic [rv_pkg::word_width-1:0] imm,
  output logic [rv_pkg::word_width-1:0] inst,
  output logic [rv_pkg::word_width-1:0] pc,
  output logic                          fetch_req_valid,
  output logic [rv_pkg::word_width-1:0] fetch_req_addr,
  input  logic                          fetch_req_ready,
  input  logic                          fetch_resp_valid,
  input  logic [rv_pkg::word_width-1:0] fetch_resp_rdata,
  output logic                          lsu_req_valid,
  output logic                          lsu_req_write,
  output logic [rv_pkg::word_width-1:0] lsu_req_addr,
  output logic [rv_pkg::word_width-1:0] lsu_req_wdata,
  output logic [3:0]                    lsu_req_wstrb,
  input  logic                          lsu_req_ready,
  input  logic                          lsu_resp_valid,
  input  logic [rv_pkg::word_width-1:0] lsu_resp_rdata,
  output logic                          rd_write,
  output logic [rv_pkg::word_width-1:0] rd_data,
  output logic                          commit_valid,
  output logic [rv_pkg::word_width-1:0] commit_pc,
  output logic                          halted
);
  import rv_pkg::*;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_wait,
    st_execute,
    st_mem,
    st_mem_wait,
    st_halt
  } state_t;

  state_t                state;
  opcode_t               opcode;
  logic                  is_mem;
  logic                  retire;
  logic [word_width-1:0] pc_plus4;
  logic [word_width-1:0] jalr_sum;
  logic [word_width-1:0] next_pc;

  assign opcode   = opcode_t'(inst[6:0]);
  assign is_mem   = (inst_class == class_load) || (inst_class == class_store);
  assign pc_plus4 = pc + 4;
  assign jalr_sum = rs1_data + imm;
  assign retire   = (state == st_execute && !is_mem) || (state == st_mem_wait && lsu_resp_valid);

  always_comb begin
    case (inst_class)
      class_branch:        next_pc = branch_taken ? alu_result : pc_plus4; // Target pc+imm.
      class_jump:          next_pc = alu_result;
      class_jump_register: next_pc = {jalr_sum[word_width-1:1], 1'b0};
      default:             next_pc = pc_plus4;
    endcase
  end

  // Writeback source.
  always_comb begin
    if (state == st_mem_wait) begin
      rd_data = lsu_resp_rdata;
    end else if (opcode == op_lui) begin
      rd_data = imm;
    end else if (inst_class == class_jump || inst_class == class_jump_register) begin
      rd_data = pc_plus4; // Link value.
    end else begin
      rd_data = alu_result;
    end
  end

  assign rd_write = (state == st_execute && (inst_class == class_alu ||
                     inst_class == class_jump || inst_class == class_jump_register)) ||
                    (state == st_mem_wait && lsu_resp_valid && inst_class == class_load);

  assign fetch_req_addr = pc;
  assign lsu_req_valid  = (state == st_mem);
  assign lsu_req_write  = (inst_class == class_store);
  assign lsu_req_addr   = alu_result;
  assign lsu_req_wdata  = rs2_data;
  assign lsu_req_wstrb  = 4'hf; // Word stores only.

  always_ff @(posedge clock) begin
    if (reset) begin
      state           <= st_fetch;
      pc              <= reset_pc;
      fetch_req_valid <= 1'b0;
      commit_valid    <= 1'b0;
      halted          <= 1'b0;
    end else begin
      commit_valid <= retire;
      case (state)
        st_fetch: begin
          if (fetch_req_valid && fetch_req_ready) begin
            fetch_req_valid <= 1'b0;
            state           <= st_fetch_wait;
          end else begin
            fetch_req_valid <= 1'b1;
          end
        end
        st_fetch_wait: begin
          if (fetch_resp_valid) state <= st_execute;
        end
        st_execute: begin
          if (is_mem) begin
            state <= st_mem;
          end else if (inst_class == class_halt) begin
            halted <= 1'b1;
            state  <= st_halt;
          end else begin
            pc    <= next_pc; // Illegal falls through as a no-op.
            state <= st_fetch;
          end
        end
        st_mem: begin
          if (lsu_req_ready) state <= st_mem_wait;
        end
        st_mem_wait: begin
          if (lsu_resp_valid) begin
            pc    <= pc_plus4;
            state <= st_fetch;
          end
        end
        default: state <= st_halt;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_fetch_wait && fetch_resp_valid) inst <= fetch_resp_rdata;
    if (retire) commit_pc <= pc;
  end

endmodule

// ==== hdl/rv_pkg.sv ====
package rv_pkg;

  parameter int word_width = 32;

  // Major opcodes, inst[6:0].
  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_imm    = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_t;

  typedef enum logic [2:0] {
    class_alu,
    class_load,
    class_store,
    class_branch,
    class_jump,
    class_jump_register,
    class_halt,
    class_illegal
  } inst_class_t;

endpackage
